/* rtl/lenet_pkg.sv */
`default_nettype none

package lenet_pkg;

    // Unsigned input or output pixel
    typedef logic [7:0] pixel_t;

    // Unsigned kernel weight
    typedef logic [7:0] weight_t;

    // Approximate multiplier result
    typedef logic [15:0] product_t;

    // Window sum, also holds the sum with bias
    // 25 full products plus a bias still fit with room to spare
    typedef logic signed [23:0] acc_t;

    // Signed bias
    typedef logic signed [15:0] bias_t;

endpackage

`default_nettype wire

/* rtl/lenet_approx_mul.sv */
`timescale 1ns/100ps
`default_nettype none

module lenet_approx_mul import lenet_pkg::*; (
    input  wire pixel_t   x,
    input  wire weight_t  y,
    output product_t      z
);

    // One partial-product row per multiplier bit
    logic [7:0] pp [8];

    // Sparse term vectors that stand in for rows 0 to 5
    logic [12:0] s1;
    logic [12:0] s2;
    logic [12:0] s3;
    logic [12:0] s4;
    logic [12:0] s5;
    logic [12:0] s6;

    always_comb begin
        for (int i = 0; i < 8; i++) begin
            pp[i] = y & {8{x[i]}};
        end
    end

    always_comb begin
        s1 = '0;
        s1[2]  = pp[0][1] ^ pp[1][0];
        s1[4]  = pp[2][1] | pp[3][0];
        s1[5]  = pp[4][1] ^ pp[5][0];
        s1[6]  = pp[0][5] | pp[1][4];
        s1[7]  = pp[0][7] ^ pp[1][6];
        s1[8]  = pp[1][7];
        s1[9]  = pp[2][7] & pp[3][6];
        s1[10] = pp[3][7];
        s1[11] = pp[4][7] & pp[5][6];
        s1[12] = pp[5][7];
    end

    always_comb begin
        s2 = '0;
        s2[2]  = pp[0][2] | pp[1][1];
        s2[7]  = pp[2][4] | pp[3][3];
        s2[8]  = pp[2][5] & pp[3][4];
        s2[9]  = pp[2][7] | pp[3][6];
        s2[10] = pp[4][5] & pp[5][4];
        s2[11] = pp[4][7] | pp[5][6];
    end

    always_comb begin
        s3 = '0;
        s3[7]  = pp[4][3] | pp[5][2];
        s3[8]  = pp[2][5] | pp[3][4];
        s3[9]  = pp[4][5] ^ pp[5][4];
        s3[10] = pp[4][6] & pp[5][5];
    end

    // Only a handful of terms left in the last three vectors
    always_comb begin
        s4 = '0;
        s5 = '0;
        s6 = '0;
        s4[8]  = pp[2][6] & pp[3][5];
        s4[10] = pp[4][6] | pp[5][5];
        s5[8]  = pp[2][6] ^ pp[3][5];
        s6[8]  = pp[4][4] | pp[5][3];
    end

    // Rows 6 and 7 are exact
    assign z = product_t'({pp[6], 6'b0})
             + product_t'({pp[7], 7'b0})
             + product_t'(s1)
             + product_t'(s2)
             + product_t'(s3)
             + product_t'(s4)
             + product_t'(s5)
             + product_t'(s6);

endmodule

`default_nettype wire

/* rtl/lenet_weight_bank.sv */
`timescale 1ns/100ps
`default_nettype none

module lenet_weight_bank import lenet_pkg::*; #(
    parameter  int TAPS  = 25,
    localparam int IDX_W = (TAPS > 1) ? $clog2(TAPS) : 1
) (
    input  wire              clk,
    input  wire              rst,
    input  wire              wt_we,
    input  wire [IDX_W-1:0]  wt_addr,
    input  wire weight_t     wt_data,
    input  wire              bias_we,
    input  wire bias_t       bias_data,
    input  wire [IDX_W-1:0]  rd_addr,
    output weight_t          rd_weight,
    output bias_t            bias
);

    weight_t weights [TAPS];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < TAPS; i++) begin
                weights[i] <= '0;
            end
        end else if (wt_we && (wt_addr < TAPS)) begin
            weights[wt_addr] <= wt_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            bias <= '0;
        end else if (bias_we) begin
            bias <= bias_data;
        end
    end

    // Combinational read, out-of-range index reads as zero
    always_comb begin
        if (rd_addr < TAPS) begin
            rd_weight = weights[rd_addr];
        end else begin
            rd_weight = '0;
        end
    end

endmodule

`default_nettype wire

/* rtl/lenet_tap_feed.sv */
`timescale 1ns/100ps
`default_nettype none

module lenet_tap_feed import lenet_pkg::*; #(
    parameter  int TAPS  = 25,
    localparam int IDX_W = (TAPS > 1) ? $clog2(TAPS) : 1
) (
    input  wire              clk,
    input  wire              rst,
    input  wire              pix_valid,
    input  wire pixel_t      pix_data,
    output logic [IDX_W-1:0] rd_addr,
    input  wire weight_t     rd_weight,
    output logic             tap_valid,
    output pixel_t           tap_pixel,
    output weight_t          tap_weight,
    output logic             tap_first,
    output logic             tap_last
);

    localparam logic [IDX_W-1:0] LAST_TAP = IDX_W'(TAPS - 1);

    // Position of the next pixel inside its window
    logic [IDX_W-1:0] tap_cnt;

    always_ff @(posedge clk) begin
        if (rst) begin
            tap_cnt <= '0;
        end else if (pix_valid) begin
            if (tap_cnt == LAST_TAP) begin
                tap_cnt <= '0;
            end else begin
                tap_cnt <= tap_cnt + 1'b1;
            end
        end
    end

    // Weight comes back in the same cycle
    assign rd_addr = tap_cnt;

    always_ff @(posedge clk) begin
        if (rst) begin
            tap_valid <= 1'b0;
            tap_first <= 1'b0;
            tap_last  <= 1'b0;
        end else begin
            tap_valid <= pix_valid;
            tap_first <= pix_valid && (tap_cnt == '0);
            tap_last  <= pix_valid && (tap_cnt == LAST_TAP);
        end
    end

    always_ff @(posedge clk) begin
        if (pix_valid) begin
            tap_pixel  <= pix_data;
            tap_weight <= rd_weight;
        end
    end

endmodule

`default_nettype wire

/* rtl/lenet_mac.sv */
`timescale 1ns/100ps
`default_nettype none

module lenet_mac import lenet_pkg::*; (
    input  wire          clk,
    input  wire          rst,
    input  wire          tap_valid,
    input  wire pixel_t  tap_pixel,
    input  wire weight_t tap_weight,
    input  wire          tap_first,
    input  wire          tap_last,
    output logic         sum_valid,
    output acc_t         sum
);

    product_t mul_z;

    // Stage one
    logic     prod_valid;
    logic     prod_first;
    logic     prod_last;
    product_t prod;

    // Stage two
    acc_t acc;
    acc_t prod_ext;

    lenet_approx_mul u_mul (
        .x (tap_pixel),
        .y (tap_weight),
        .z (mul_z)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            prod_valid <= 1'b0;
            prod_first <= 1'b0;
            prod_last  <= 1'b0;
        end else begin
            prod_valid <= tap_valid;
            prod_first <= tap_valid && tap_first;
            prod_last  <= tap_valid && tap_last;
        end
    end

    always_ff @(posedge clk) begin
        if (tap_valid) begin
            prod <= mul_z;
        end
    end

    // Products are unsigned, zero-extend into the signed sum
    assign prod_ext = acc_t'({8'b0, prod});

    // First tap reloads, so a new window needs no bubble
    always_ff @(posedge clk) begin
        if (prod_valid) begin
            if (prod_first) begin
                acc <= prod_ext;
            end else begin
                acc <= acc + prod_ext;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            sum_valid <= 1'b0;
        end else begin
            sum_valid <= prod_valid && prod_last;
        end
    end

    assign sum = acc;

endmodule

`default_nettype wire

/* rtl/lenet_activation.sv */
`timescale 1ns/100ps
`default_nettype none

module lenet_activation import lenet_pkg::*; #(
    parameter int SHIFT = 8
) (
    input  wire        clk,
    input  wire        rst,
    input  wire        sum_valid,
    input  wire acc_t  sum,
    input  wire bias_t bias,
    output logic       out_valid,
    output pixel_t     out_pixel
);

    acc_t        biased;
    acc_t        relu;
    logic [23:0] shifted;
    pixel_t      sat;

    always_comb begin
        biased = sum + acc_t'(bias);

        // ReLU
        if (biased < 0) begin
            relu = '0;
        end else begin
            relu = biased;
        end

        // Value is non-negative here, a logical shift is enough
        shifted = unsigned'(relu) >> SHIFT;

        if (shifted > 24'd255) begin
            sat = 8'hff;
        end else begin
            sat = shifted[7:0];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= sum_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (sum_valid) begin
            out_pixel <= sat;
        end
    end

endmodule

`default_nettype wire

/* rtl/lenet_conv_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module lenet_conv_unit import lenet_pkg::*; #(
    parameter  int TAPS  = 25,
    parameter  int SHIFT = 8,
    localparam int IDX_W = (TAPS > 1) ? $clog2(TAPS) : 1
) (
    input  wire              clk,
    input  wire              rst,
    input  wire              wt_we,
    input  wire [IDX_W-1:0]  wt_addr,
    input  wire weight_t     wt_data,
    input  wire              bias_we,
    input  wire bias_t       bias_data,
    input  wire              pix_valid,
    input  wire pixel_t      pix_data,
    output logic             out_valid,
    output pixel_t           out_pixel
);

    logic [IDX_W-1:0] rd_addr;
    weight_t          rd_weight;
    bias_t            bias;

    logic    tap_valid;
    pixel_t  tap_pixel;
    weight_t tap_weight;
    logic    tap_first;
    logic    tap_last;

    logic sum_valid;
    acc_t sum;

    lenet_weight_bank #(
        .TAPS (TAPS)
    ) u_bank (
        .clk       (clk),
        .rst       (rst),
        .wt_we     (wt_we),
        .wt_addr   (wt_addr),
        .wt_data   (wt_data),
        .bias_we   (bias_we),
        .bias_data (bias_data),
        .rd_addr   (rd_addr),
        .rd_weight (rd_weight),
        .bias      (bias)
    );

    lenet_tap_feed #(
        .TAPS (TAPS)
    ) u_feed (
        .clk        (clk),
        .rst        (rst),
        .pix_valid  (pix_valid),
        .pix_data   (pix_data),
        .rd_addr    (rd_addr),
        .rd_weight  (rd_weight),
        .tap_valid  (tap_valid),
        .tap_pixel  (tap_pixel),
        .tap_weight (tap_weight),
        .tap_first  (tap_first),
        .tap_last   (tap_last)
    );

    lenet_mac u_mac (
        .clk        (clk),
        .rst        (rst),
        .tap_valid  (tap_valid),
        .tap_pixel  (tap_pixel),
        .tap_weight (tap_weight),
        .tap_first  (tap_first),
        .tap_last   (tap_last),
        .sum_valid  (sum_valid),
        .sum        (sum)
    );

    lenet_activation #(
        .SHIFT (SHIFT)
    ) u_act (
        .clk       (clk),
        .rst       (rst),
        .sum_valid (sum_valid),
        .sum       (sum),
        .bias      (bias),
        .out_valid (out_valid),
        .out_pixel (out_pixel)
    );

endmodule

`default_nettype wire

/* test/tb_lenet_model.svh */
`ifndef TB_LENET_MODEL_SVH
`define TB_LENET_MODEL_SVH

// Bit j of partial-product row i
function automatic int pp_bit(input logic [7:0] x, input logic [7:0] y, input int i, input int j);
    return (x[i] & y[j]) ? 1 : 0;
endfunction

// Rows 6 and 7 exact, rows 0 to 5 reduced to sparse single-bit terms
function automatic int approx_product(input logic [7:0] x, input logic [7:0] y);
    int z;
    z = 0;
    if (x[6]) begin
        z += int'(y) * 64;
    end
    if (x[7]) begin
        z += int'(y) * 128;
    end
    z += 4 * ((pp_bit(x, y, 0, 1) ^ pp_bit(x, y, 1, 0))
            + (pp_bit(x, y, 0, 2) | pp_bit(x, y, 1, 1)));
    z += 16 * (pp_bit(x, y, 2, 1) | pp_bit(x, y, 3, 0));
    z += 32 * (pp_bit(x, y, 4, 1) ^ pp_bit(x, y, 5, 0));
    z += 64 * (pp_bit(x, y, 0, 5) | pp_bit(x, y, 1, 4));
    z += 128 * ((pp_bit(x, y, 0, 7) ^ pp_bit(x, y, 1, 6))
              + (pp_bit(x, y, 2, 4) | pp_bit(x, y, 3, 3))
              + (pp_bit(x, y, 4, 3) | pp_bit(x, y, 5, 2)));
    z += 256 * (pp_bit(x, y, 1, 7)
              + (pp_bit(x, y, 2, 5) & pp_bit(x, y, 3, 4))
              + (pp_bit(x, y, 2, 5) | pp_bit(x, y, 3, 4))
              + (pp_bit(x, y, 2, 6) & pp_bit(x, y, 3, 5))
              + (pp_bit(x, y, 2, 6) ^ pp_bit(x, y, 3, 5))
              + (pp_bit(x, y, 4, 4) | pp_bit(x, y, 5, 3)));
    z += 512 * ((pp_bit(x, y, 2, 7) & pp_bit(x, y, 3, 6))
              + (pp_bit(x, y, 2, 7) | pp_bit(x, y, 3, 6))
              + (pp_bit(x, y, 4, 5) ^ pp_bit(x, y, 5, 4)));
    z += 1024 * (pp_bit(x, y, 3, 7)
               + (pp_bit(x, y, 4, 5) & pp_bit(x, y, 5, 4))
               + (pp_bit(x, y, 4, 6) & pp_bit(x, y, 5, 5))
               + (pp_bit(x, y, 4, 6) | pp_bit(x, y, 5, 5)));
    z += 2048 * ((pp_bit(x, y, 4, 7) & pp_bit(x, y, 5, 6))
               + (pp_bit(x, y, 4, 7) | pp_bit(x, y, 5, 6)));
    z += 4096 * pp_bit(x, y, 5, 7);
    // 16-bit result wraps
    return z % 65536;
endfunction

// Bias add, ReLU, right shift, saturate to one pixel
function automatic int activate_sum(input int total, input int b, input int shift);
    int v;
    v = total + b;
    if (v < 0) begin
        v = 0;
    end
    v = v >> shift;
    return (v > 255) ? 255 : v;
endfunction

`endif

/* test/tb_lenet_conv_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_lenet_conv_unit import lenet_pkg::*; ;

    localparam int TAPS       = 25;
    localparam int SHIFT      = 8;
    localparam int IDX_W      = $clog2(TAPS);
    localparam int CLK_PERIOD = 40;
    localparam int N_RAND     = 10;
    // Windows over all tests, gap allowance per tap, and margin for loads and drains
    localparam int TOTAL_WINDOWS   = 1 + 3 * N_RAND + 2 + 6;
    localparam int WATCHDOG_CYCLES = TOTAL_WINDOWS * TAPS * 4 + 3000;

    logic             clk;
    logic             rst;
    logic             wt_we;
    logic [IDX_W-1:0] wt_addr;
    weight_t          wt_data;
    logic             bias_we;
    bias_t            bias_data;
    logic             pix_valid;
    pixel_t           pix_data;
    logic             out_valid;
    pixel_t           out_pixel;

    int          edge_cnt = 0;
    int          err_count = 0;
    int          out_valid_cnt = 0;
    int          tests_passed = 0;
    int          tests_failed = 0;
    logic [31:0] rand_state = 32'had4;
    weight_t     weight_mem [TAPS];
    int          bias_val;
    int          exp_pix_q [$];
    int          exp_cyc_q [$];

    `include "tb_lenet_model.svh"

    lenet_conv_unit dut0 (
        .clk       (clk),
        .rst       (rst),
        .wt_we     (wt_we),
        .wt_addr   (wt_addr),
        .wt_data   (wt_data),
        .bias_we   (bias_we),
        .bias_data (bias_data),
        .pix_valid (pix_valid),
        .pix_data  (pix_data),
        .out_valid (out_valid),
        .out_pixel (out_pixel)
    );

    // Edge count moves before the edge so waiting processes see the new index
    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2);
            edge_cnt = edge_cnt + 1;
            clk = 1'b1;
            #(CLK_PERIOD / 2);
            clk = 1'b0;
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Simulation finished: FAIL");
        $finish;
    end

    function automatic int rand16();
        rand_state = rand_state * 32'd1664525 + 32'd1013904223;
        return int'(rand_state[31:16]);
    endfunction

    // Mostly zero taps keep window sums below saturation
    function automatic weight_t random_weight();
        int r;
        r = rand16();
        if ((r >> 14) != 0) begin
            return '0;
        end
        return weight_t'((r & 255) >> ((r >> 8) % 6));
    endfunction

    function automatic int random_bias();
        bias_t b;
        b = bias_t'(rand16());
        return int'(b);
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t: %s expected %0d, got %0d",
                     $time, name, expected, actual);
            err_count++;
        end
    endtask

    // Outputs are stable at the falling edge
    always @(negedge clk) begin
        if (out_valid === 1'b1) begin
            out_valid_cnt++;
            if (exp_pix_q.size() == 0) begin
                $display("Unexpected out_valid at %0t with no window pending", $time);
                err_count++;
            end else begin
                check_value("out_pixel", exp_pix_q.pop_front(), out_pixel);
                check_value("out_valid cycle", exp_cyc_q.pop_front(), edge_cnt);
            end
        end
    end

    // Mode 0 random, mode 1 all 255
    task automatic load_weights(input int mode);
        weight_t w;
        for (int i = 0; i < TAPS; i++) begin
            w = (mode == 1) ? 8'hff : random_weight();
            @(posedge clk);
            wt_we   <= 1'b1;
            wt_addr <= IDX_W'(i);
            wt_data <= w;
            weight_mem[i] = w;
        end
        @(posedge clk);
        wt_we <= 1'b0;
    endtask

    // Addresses past the last tap must be dropped by the bank
    task automatic write_stray_weights();
        for (int a = TAPS; a < (1 << IDX_W); a++) begin
            @(posedge clk);
            wt_we   <= 1'b1;
            wt_addr <= IDX_W'(a);
            wt_data <= weight_t'(rand16());
        end
        @(posedge clk);
        wt_we <= 1'b0;
    endtask

    task automatic write_bias(input int b);
        @(posedge clk);
        bias_we   <= 1'b1;
        bias_data <= bias_t'(b);
        bias_val = b;
        @(posedge clk);
        bias_we <= 1'b0;
    endtask

    // Pixel mode 0 zero, 1 random, 2 multiples of 64, 3 all 255, 4 small
    task automatic send_window(input int mode, input int gap_pct, input bit exact,
                               input int forced);
        pixel_t p;
        int     total;
        int     expv;
        total = 0;
        for (int t = 0; t < TAPS; t++) begin
            case (mode)
                0: p = 8'd0;
                1: p = pixel_t'(rand16());
                2: p = pixel_t'((rand16() % 4) * 64);
                3: p = 8'hff;
                default: p = pixel_t'(rand16() % 4);
            endcase
            while ((rand16() % 100) < gap_pct) begin
                @(posedge clk);
                pix_valid <= 1'b0;
                pix_data  <= pixel_t'(rand16());
            end
            @(posedge clk);
            pix_valid <= 1'b1;
            pix_data  <= p;
            if (exact) begin
                total += int'(p) * int'(weight_mem[t]);
            end else begin
                total += approx_product(p, weight_mem[t]);
            end
        end
        expv = (forced >= 0) ? forced : activate_sum(total, bias_val, SHIFT);
        exp_pix_q.push_back(expv);
        exp_cyc_q.push_back(edge_cnt + 4);
    endtask

    task automatic drain_pipeline();
        int waited;
        @(posedge clk);
        pix_valid <= 1'b0;
        waited = 0;
        while (exp_pix_q.size() != 0 && waited < 20) begin
            @(posedge clk);
            waited++;
        end
        if (exp_pix_q.size() != 0) begin
            $display("Output missing: %0d windows gave no out_valid", exp_pix_q.size());
            err_count++;
            exp_pix_q.delete();
            exp_cyc_q.delete();
        end
        repeat (2) @(posedge clk);
    endtask

    task automatic end_test(input string name, input int errs_before);
        if (err_count == errs_before) begin
            $display("test %s: passed", name);
            tests_passed++;
        end else begin
            $display("test %s: failed with %0d errors", name, err_count - errs_before);
            tests_failed++;
        end
    endtask

    initial begin
        int errs;
        int seen;
        rst       = 1'b1;
        wt_we     = 1'b0;
        wt_addr   = '0;
        wt_data   = '0;
        bias_we   = 1'b0;
        bias_data = '0;
        pix_valid = 1'b0;
        pix_data  = '0;
        bias_val  = 0;
        for (int i = 0; i < TAPS; i++) begin
            weight_mem[i] = '0;
        end
        repeat (4) @(posedge clk);
        rst <= 1'b0;

        errs = err_count;
        seen = out_valid_cnt;
        repeat (20) @(posedge clk);
        check_value("out_valid count", 0, out_valid_cnt - seen);
        send_window(0, 0, 1'b0, 0);
        drain_pipeline();
        end_test("reset and zero window", errs);

        // Multiples of 64 touch only the exact rows
        errs = err_count;
        load_weights(0);
        write_bias(random_bias());
        for (int n = 0; n < N_RAND; n++) begin
            send_window(2, 0, 1'b1, -1);
        end
        drain_pipeline();
        end_test("exact rows", errs);

        errs = err_count;
        load_weights(0);
        write_bias(random_bias());
        for (int n = 0; n < N_RAND; n++) begin
            send_window(1, 0, 1'b0, -1);
        end
        drain_pipeline();
        end_test("random windows", errs);

        errs = err_count;
        for (int n = 0; n < N_RAND; n++) begin
            send_window(1, 30, 1'b0, -1);
        end
        drain_pipeline();
        end_test("windows with gaps", errs);

        // Small pixels keep the sum well below the bias magnitude
        errs = err_count;
        write_bias(-32768);
        send_window(4, 0, 1'b0, 0);
        drain_pipeline();
        load_weights(1);
        write_bias(1000);
        send_window(3, 0, 1'b0, 255);
        drain_pipeline();
        end_test("activation limits", errs);

        errs = err_count;
        load_weights(0);
        write_bias(random_bias());
        for (int n = 0; n < 3; n++) begin
            send_window(1, 10, 1'b0, -1);
        end
        drain_pipeline();
        write_stray_weights();
        for (int n = 0; n < 3; n++) begin
            send_window(1, 10, 1'b0, -1);
        end
        drain_pipeline();
        end_test("reload and stray writes", errs);

        if (exp_pix_q.size() != 0) begin
            $display("Scoreboard still holds %0d expected outputs at the end", exp_pix_q.size());
            err_count++;
        end
        $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
        if (err_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* compile.f */
+incdir+test
rtl/lenet_pkg.sv
rtl/lenet_approx_mul.sv
rtl/lenet_weight_bank.sv
rtl/lenet_tap_feed.sv
rtl/lenet_mac.sv
rtl/lenet_activation.sv
rtl/lenet_conv_unit.sv
test/tb_lenet_conv_unit.sv
